//--- design/rsa_pkg.sv
package rsa_pkg;

  // ##########################################################################
  // array geometry
  // ##########################################################################

  localparam int RSA_LANES = 4;                      // lanes per row.
  localparam int RSA_DW    = 32;                     // signed word per lane.
  localparam int ROW_W     = RSA_LANES * RSA_DW;     // one full row.

  // ##########################################################################
  // buffer depths and flow control
  // ##########################################################################

  localparam int CB_DEPTH    = 16;                   // coefficient buffer rows.
  localparam int CB_AW       = $clog2(CB_DEPTH);
  localparam int CMD_DEPTH   = 4;                    // also the upstream credits.
  localparam int CMD_AW      = $clog2(CMD_DEPTH);
  localparam int OUT_CREDITS = 4;                    // downstream slots.
  localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

  // issue to o_out_valid: fetch, relu, map.
  localparam int PIPE_LAT = 3;

  // ##########################################################################
  // command fields
  // ##########################################################################

  typedef enum logic {
    SRC_CB         = 1'b0,                           // row straight from the buffer.
    SRC_NON_LINEAR = 1'b1                            // row after relu.
  } src_e;

  // lane placement into the temporary buffer.
  typedef enum logic [1:0] {
    DIR_IDLE = 2'b00,                                // all lanes zero.
    DIR_POS  = 2'b01,                                // lanes straight.
    DIR_NEG  = 2'b10,                                // lanes reversed.
    DIR_NEW  = 2'b11                                 // half placed, picked by l_k_0.
  } dir_e;

endpackage

//--- design/lane_bus_if.sv
`timescale 1ns/10ps

interface lane_bus_if;

  logic                       valid;
  rsa_pkg::src_e              src;
  rsa_pkg::dir_e              dir;
  logic                       l_k_0;
  logic [rsa_pkg::ROW_W-1:0]  raw_row;
  logic [rsa_pkg::ROW_W-1:0]  nl_row;               // filled in by the relu stage.

  // full row with both copies.
  modport producer (output valid, src, dir, l_k_0, raw_row, nl_row);
  modport consumer (input  valid, src, dir, l_k_0, raw_row, nl_row);

  // head of the pipe, before the relu copy exists.
  modport producer_raw (output valid, src, dir, l_k_0, raw_row);
  modport consumer_raw (input  valid, src, dir, l_k_0, raw_row);

endinterface

//--- design/cb_fetch_stage.sv
`timescale 1ns/10ps

module cb_fetch_stage (
  input  logic                        clk,
  input  logic                        sys_rst,
  input  logic                        i_cb_wr_en,
  input  logic [rsa_pkg::CB_AW-1:0]   i_cb_wr_addr,
  input  logic [rsa_pkg::ROW_W-1:0]   i_cb_wr_data,
  input  logic                        i_cmd_valid,
  input  logic [rsa_pkg::CB_AW-1:0]   i_cmd_addr,
  input  rsa_pkg::src_e               i_cmd_src,
  input  rsa_pkg::dir_e               i_cmd_dir,
  input  logic                        i_cmd_l_k_0,
  input  logic                        i_out_credit,
  output logic                        o_cmd_credit,
  lane_bus_if.producer_raw            bus_o
);

  // ##########################################################################
  // command fifo
  // ##########################################################################

  logic [rsa_pkg::CB_AW-1:0]     fifo_addr  [rsa_pkg::CMD_DEPTH];
  rsa_pkg::src_e                 fifo_src   [rsa_pkg::CMD_DEPTH];
  rsa_pkg::dir_e                 fifo_dir   [rsa_pkg::CMD_DEPTH];
  logic                          fifo_l_k_0 [rsa_pkg::CMD_DEPTH];

  logic [rsa_pkg::CMD_AW-1:0]    wr_ptr;
  logic [rsa_pkg::CMD_AW-1:0]    rd_ptr;
  logic [rsa_pkg::CMD_AW:0]      count;
  logic [rsa_pkg::CREDIT_W-1:0]  credit_cnt;

  logic [rsa_pkg::ROW_W-1:0]     cb_mem [rsa_pkg::CB_DEPTH];

  logic fifo_empty;
  logic fifo_full;
  logic push;
  logic issue;

  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == rsa_pkg::CMD_DEPTH[rsa_pkg::CMD_AW:0]);
  assign push       = i_cmd_valid && !fifo_full;      // credits keep this from dropping.
  assign issue      = !fifo_empty && (credit_cnt != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_addr[wr_ptr]  <= i_cmd_addr;
      fifo_src[wr_ptr]   <= i_cmd_src;
      fifo_dir[wr_ptr]   <= i_cmd_dir;
      fifo_l_k_0[wr_ptr] <= i_cmd_l_k_0;
    end
  end

  // ##########################################################################
  // pointers, credits
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      credit_cnt   <= rsa_pkg::OUT_CREDITS[rsa_pkg::CREDIT_W-1:0];
      o_cmd_credit <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (issue)
        rd_ptr <= rd_ptr + 1'b1;

      case ({push, issue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // issue and return together leave the count alone.
      case ({issue, i_out_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase

      o_cmd_credit <= issue;                         // one slot freed per pop.
    end
  end

  // ##########################################################################
  // coefficient buffer
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (i_cb_wr_en)
      cb_mem[i_cb_wr_addr] <= i_cb_wr_data;
  end

  always_ff @(posedge clk) begin
    if (sys_rst)
      bus_o.valid <= 1'b0;
    else
      bus_o.valid <= issue;
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      bus_o.raw_row <= cb_mem[fifo_addr[rd_ptr]];    // old data on a same-cycle write.
      bus_o.src     <= fifo_src[rd_ptr];
      bus_o.dir     <= fifo_dir[rd_ptr];
      bus_o.l_k_0   <= fifo_l_k_0[rd_ptr];
    end
  end

endmodule

//--- design/non_linear_stage.sv
`timescale 1ns/10ps

module non_linear_stage (
  input  logic             clk,
  input  logic             sys_rst,
  lane_bus_if.consumer_raw bus_i,
  lane_bus_if.producer     bus_o
);

  logic [rsa_pkg::ROW_W-1:0] relu_row;

  // relu per lane, sign bit decides.
  always_comb begin
    for (int i = 0; i < rsa_pkg::RSA_LANES; i++) begin
      if (bus_i.raw_row[i*rsa_pkg::RSA_DW + rsa_pkg::RSA_DW - 1])
        relu_row[i*rsa_pkg::RSA_DW +: rsa_pkg::RSA_DW] = '0;
      else
        relu_row[i*rsa_pkg::RSA_DW +: rsa_pkg::RSA_DW] =
          bus_i.raw_row[i*rsa_pkg::RSA_DW +: rsa_pkg::RSA_DW];
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst)
      bus_o.valid <= 1'b0;
    else
      bus_o.valid <= bus_i.valid;
  end

  always_ff @(posedge clk) begin
    bus_o.src     <= bus_i.src;
    bus_o.dir     <= bus_i.dir;
    bus_o.l_k_0   <= bus_i.l_k_0;
    bus_o.raw_row <= bus_i.raw_row;                  // raw copy rides along.
    bus_o.nl_row  <= relu_row;
  end

endmodule

//--- design/tb_dina_map.sv
`timescale 1ns/10ps

module tb_dina_map (
  input  logic                       clk,
  input  logic                       sys_rst,
  lane_bus_if.consumer               bus_i,
  output logic                       o_out_valid,
  output logic [rsa_pkg::ROW_W-1:0]  o_out_data
);

  localparam int DW = rsa_pkg::RSA_DW;
  localparam int NL = rsa_pkg::RSA_LANES;

  logic [rsa_pkg::ROW_W-1:0] src_row;
  logic [rsa_pkg::ROW_W-1:0] map_row;

  assign src_row = (bus_i.src == rsa_pkg::SRC_NON_LINEAR) ? bus_i.nl_row : bus_i.raw_row;

  // ##########################################################################
  // lane placement
  // ##########################################################################

  always_comb begin
    map_row = '0;
    case (bus_i.dir)
      rsa_pkg::DIR_POS: begin
        map_row = src_row;
      end
      rsa_pkg::DIR_NEG: begin
        for (int i = 0; i < NL; i++)
          map_row[i*DW +: DW] = src_row[(NL-1-i)*DW +: DW];
      end
      rsa_pkg::DIR_NEW: begin
        // lanes 0 and 1 of the source go low or high.
        if (bus_i.l_k_0) begin
          map_row[0*DW +: DW] = src_row[0*DW +: DW];
          map_row[1*DW +: DW] = src_row[1*DW +: DW];
        end else begin
          map_row[2*DW +: DW] = src_row[0*DW +: DW];
          map_row[3*DW +: DW] = src_row[1*DW +: DW];
        end
      end
      default: begin
        map_row = '0;                                // idle row.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst)
      o_out_valid <= 1'b0;
    else
      o_out_valid <= bus_i.valid;
  end

  always_ff @(posedge clk) begin
    o_out_data <= map_row;
  end

endmodule

//--- design/tb_dina_pipe.sv
`timescale 1ns/10ps

module tb_dina_pipe (
  input  logic                        clk,
  input  logic                        sys_rst,
  input  logic                        i_cb_wr_en,
  input  logic [rsa_pkg::CB_AW-1:0]   i_cb_wr_addr,
  input  logic [rsa_pkg::ROW_W-1:0]   i_cb_wr_data,
  input  logic                        i_cmd_valid,
  input  logic [rsa_pkg::CB_AW-1:0]   i_cmd_addr,
  input  rsa_pkg::src_e               i_cmd_src,
  input  rsa_pkg::dir_e               i_cmd_dir,
  input  logic                        i_cmd_l_k_0,
  input  logic                        i_out_credit,
  output logic                        o_cmd_credit,
  output logic                        o_out_valid,
  output logic [rsa_pkg::ROW_W-1:0]   o_out_data
);

  lane_bus_if fetch_bus ();                          // buffer row out of fetch.
  lane_bus_if nl_bus ();                             // raw and relu rows.

  cb_fetch_stage cb_fetch_stage_i (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_cb_wr_en   (i_cb_wr_en),
    .i_cb_wr_addr (i_cb_wr_addr),
    .i_cb_wr_data (i_cb_wr_data),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_addr   (i_cmd_addr),
    .i_cmd_src    (i_cmd_src),
    .i_cmd_dir    (i_cmd_dir),
    .i_cmd_l_k_0  (i_cmd_l_k_0),
    .i_out_credit (i_out_credit),
    .o_cmd_credit (o_cmd_credit),
    .bus_o        (fetch_bus.producer_raw)
  );

  non_linear_stage non_linear_stage_i (
    .clk     (clk),
    .sys_rst (sys_rst),
    .bus_i   (fetch_bus.consumer_raw),
    .bus_o   (nl_bus.producer)
  );

  tb_dina_map tb_dina_map_i (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .bus_i       (nl_bus.consumer),
    .o_out_valid (o_out_valid),
    .o_out_data  (o_out_data)
  );

endmodule

//--- bench/tb_dina_pipe_tb.sv
`timescale 1ns/10ps

module tb_dina_pipe_tb;

  localparam int DW          = rsa_pkg::RSA_DW;
  localparam int N_CMDS      = 101;                  // commands over all tests.
  localparam int TIMEOUT_CYC = 64 * N_CMDS + 200;

  logic                        clk = 1'b0;
  logic                        sys_rst;
  logic                        i_cb_wr_en;
  logic [rsa_pkg::CB_AW-1:0]   i_cb_wr_addr;
  logic [rsa_pkg::ROW_W-1:0]   i_cb_wr_data;
  logic                        i_cmd_valid;
  logic [rsa_pkg::CB_AW-1:0]   i_cmd_addr;
  rsa_pkg::src_e               i_cmd_src;
  rsa_pkg::dir_e               i_cmd_dir;
  logic                        i_cmd_l_k_0;
  logic                        i_out_credit;
  logic                        o_cmd_credit;
  logic                        o_out_valid;
  logic [rsa_pkg::ROW_W-1:0]   o_out_data;

  logic [rsa_pkg::ROW_W-1:0]   cb_model [$];        // copy of the buffer.
  logic [rsa_pkg::ROW_W-1:0]   exp_rows [$];        // one per command, in order.
  int                          out_cyc [$];
  int          cyc;
  int          cmds_sent;
  int          credit_pulses;
  int          rows_seen;
  int          owed;
  int          mon_errs;
  int          chk_errs;
  int          err_mark;
  int          tests_run;
  int          tests_failed;
  int          last_send_cyc;
  int          base;
  int          pulse_base;
  logic        hold;
  logic [31:0] rng;
  string       cur_test;

  tb_dina_pipe tb_dina_pipe_i (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .i_cb_wr_en   (i_cb_wr_en),
    .i_cb_wr_addr (i_cb_wr_addr),
    .i_cb_wr_data (i_cb_wr_data),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_addr   (i_cmd_addr),
    .i_cmd_src    (i_cmd_src),
    .i_cmd_dir    (i_cmd_dir),
    .i_cmd_l_k_0  (i_cmd_l_k_0),
    .i_out_credit (i_out_credit),
    .o_cmd_credit (o_cmd_credit),
    .o_out_valid  (o_out_valid),
    .o_out_data   (o_out_data)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ##########################################################################
  // reference model
  // ##########################################################################

  function automatic logic [rsa_pkg::ROW_W-1:0] expect_row(
    input logic [rsa_pkg::ROW_W-1:0] row,
    input rsa_pkg::src_e             src,
    input rsa_pkg::dir_e             dir,
    input logic                      lk
  );
    logic [rsa_pkg::ROW_W-1:0] s;
    logic [rsa_pkg::ROW_W-1:0] d;
    s = row;
    d = '0;
    for (int i = 0; i < rsa_pkg::RSA_LANES; i++) begin
      if (src == rsa_pkg::SRC_NON_LINEAR && $signed(s[i*DW +: DW]) < 0)
        s[i*DW +: DW] = '0;                          // negative lanes clip to zero.
    end
    case (dir)
      rsa_pkg::DIR_POS: d = s;
      rsa_pkg::DIR_NEG: begin
        for (int i = 0; i < rsa_pkg::RSA_LANES; i++)
          d[i*DW +: DW] = s[(rsa_pkg::RSA_LANES-1-i)*DW +: DW];
      end
      rsa_pkg::DIR_NEW: begin
        if (lk)
          d[0 +: 2*DW] = s[0 +: 2*DW];               // low half.
        else
          d[2*DW +: 2*DW] = s[0 +: 2*DW];            // high half.
      end
      default: d = '0;
    endcase
    return d;
  endfunction

  task automatic load_buffer;
    logic [rsa_pkg::ROW_W-1:0] row;
    logic [DW-1:0]             w;
    for (int a = 0; a < rsa_pkg::CB_DEPTH; a++) begin
      for (int l = 0; l < rsa_pkg::RSA_LANES; l++) begin
        rng = xorshift(rng);
        w = rng;
        if (l == a % 4)
          w[DW-1] = 1'b1;                            // each row gets a negative lane.
        if (l == (a + 2) % 4)
          w[DW-1] = 1'b0;
        row[l*DW +: DW] = w;
      end
      i_cb_wr_en   = 1'b1;
      i_cb_wr_addr = a[rsa_pkg::CB_AW-1:0];
      i_cb_wr_data = row;
      cb_model.push_back(row);
      @(posedge clk);
      #1;
    end
    i_cb_wr_en = 1'b0;
  endtask

  task automatic send_cmd(input int addr, input rsa_pkg::src_e src,
                          input rsa_pkg::dir_e dir, input logic lk);
    while (cmds_sent - credit_pulses >= rsa_pkg::CMD_DEPTH) begin
      @(posedge clk);
      #1;
    end
    i_cmd_valid = 1'b1;
    i_cmd_addr  = addr[rsa_pkg::CB_AW-1:0];
    i_cmd_src   = src;
    i_cmd_dir   = dir;
    i_cmd_l_k_0 = lk;
    exp_rows.push_back(expect_row(cb_model[addr], src, dir, lk));
    cmds_sent++;
    last_send_cyc = cyc;
    @(posedge clk);
    #1;
    i_cmd_valid = 1'b0;
  endtask

  task automatic send_random(input int n);
    for (int k = 0; k < n; k++) begin
      rng = xorshift(rng);
      send_cmd(int'(rng[3:0]), rsa_pkg::src_e'(rng[4]), rsa_pkg::dir_e'(rng[6:5]), rng[7]);
    end
  endtask

  task automatic wait_drain;
    while (rows_seen < cmds_sent || owed != 0) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);                                  // last credit lands in the counter.
    #1;
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("Fail %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      chk_errs++;
    end
  endtask

  task automatic open_test(input string name);
    cur_test = name;
    err_mark = mon_errs + chk_errs;
    tests_run++;
  endtask

  task automatic close_test;
    if (mon_errs + chk_errs == err_mark) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, mon_errs + chk_errs - err_mark);
      tests_failed++;
    end
  endtask

  // ##########################################################################
  // monitors
  // ##########################################################################

  initial begin
    rows_seen     = 0;
    credit_pulses = 0;
    mon_errs      = 0;
    forever begin
      @(negedge clk);
      if (!sys_rst) begin
        if (o_cmd_credit) begin
          assert (credit_pulses < cmds_sent) else begin
            $display("upstream credit returned with no command outstanding");
            mon_errs++;
          end
          credit_pulses++;
        end
        if (o_out_valid) begin
          if (rows_seen >= cmds_sent) begin
            $display("output row %0d appeared with no command pending", rows_seen);
            mon_errs++;
          end else begin
            assert (o_out_data == exp_rows[rows_seen]) else begin
              $display("Fail %s: row %0d expected %h actual %h", cur_test, rows_seen,
                       exp_rows[rows_seen], o_out_data);
              mon_errs++;
            end
          end
          out_cyc.push_back(cyc);
          rows_seen++;
        end
      end
    end
  end

  // downstream returns one credit per row taken, unless held.
  initial begin
    i_out_credit = 1'b0;
    owed         = 0;
    forever begin
      @(posedge clk);
      #1;
      if (o_out_valid)
        owed++;
      if (!hold && owed > 0) begin
        i_out_credit = 1'b1;
        owed--;
      end else begin
        i_out_credit = 1'b0;
      end
    end
  end

  initial begin
    cyc = 0;
    while (cyc <= TIMEOUT_CYC) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout after %0d cycles, %0d of %0d rows seen", cyc, rows_seen, cmds_sent);
    $display("TEST FAIL");
    $finish;
  end

  // ##########################################################################
  // tests
  // ##########################################################################

  initial begin
    sys_rst      = 1'b1;
    i_cb_wr_en   = 1'b0;
    i_cb_wr_addr = '0;
    i_cb_wr_data = '0;
    i_cmd_valid  = 1'b0;
    i_cmd_addr   = '0;
    i_cmd_src    = rsa_pkg::SRC_CB;
    i_cmd_dir    = rsa_pkg::DIR_IDLE;
    i_cmd_l_k_0  = 1'b0;
    hold         = 1'b0;
    rng          = 32'h650d;
    cmds_sent    = 0;
    chk_errs     = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    #1;
    sys_rst = 1'b0;
    load_buffer();

    open_test("pos_neg");
    for (int a = 0; a < rsa_pkg::CB_DEPTH; a++) begin
      send_cmd(a, rsa_pkg::SRC_CB, rsa_pkg::DIR_POS, 1'b0);
      send_cmd(a, rsa_pkg::SRC_CB, rsa_pkg::DIR_NEG, 1'b0);
    end
    wait_drain();
    close_test();

    open_test("new_half");
    for (int a = 0; a < 4; a++)
      for (int k = 0; k < 4; k++)
        send_cmd(a, rsa_pkg::src_e'(k[1]), rsa_pkg::DIR_NEW, k[0]);
    wait_drain();
    close_test();

    open_test("relu_idle");
    for (int a = 0; a < rsa_pkg::CB_DEPTH; a++)
      send_cmd(a, rsa_pkg::SRC_NON_LINEAR, rsa_pkg::DIR_POS, 1'b0);
    for (int a = 0; a < 8; a++)
      send_cmd(a / 2, rsa_pkg::src_e'(a[0]), rsa_pkg::DIR_IDLE, 1'b1);
    wait_drain();
    close_test();

    open_test("backpressure");
    hold       = 1'b1;
    base       = rows_seen;
    pulse_base = credit_pulses;
    send_random(8);
    repeat (40) @(posedge clk);                      // window with no credits back.
    #1;
    check_count("rows while held", rsa_pkg::OUT_CREDITS, rows_seen - base);
    check_count("upstream credits while held", 8 - rsa_pkg::CMD_DEPTH,
                credit_pulses - pulse_base);
    hold = 1'b0;
    wait_drain();
    check_count("rows after release", 8, rows_seen - base);
    close_test();

    open_test("up_credit");
    send_random(12);
    wait_drain();
    check_count("upstream credit pulses", cmds_sent, credit_pulses);
    close_test();

    open_test("latency");
    base = cmds_sent;
    send_cmd(5, rsa_pkg::SRC_CB, rsa_pkg::DIR_POS, 1'b0);
    wait_drain();
    assert (out_cyc[base] - last_send_cyc <= 1 + rsa_pkg::PIPE_LAT) else begin
      $display("Fail %s: latency expected <= %0d actual %0d", cur_test,
               1 + rsa_pkg::PIPE_LAT, out_cyc[base] - last_send_cyc);
      chk_errs++;
    end
    base = cmds_sent;
    send_random(8);
    wait_drain();
    check_count("cycles across 8 back-to-back rows", 7, out_cyc[base+7] - out_cyc[base]);
    close_test();

    $display("%0d tests, %0d failed, %0d rows checked, %0d errors",
             tests_run, tests_failed, rows_seen, mon_errs + chk_errs);
    if (mon_errs + chk_errs == 0 && rows_seen == N_CMDS)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- files.f
design/rsa_pkg.sv
design/lane_bus_if.sv
design/cb_fetch_stage.sv
design/non_linear_stage.sv
design/tb_dina_map.sv
design/tb_dina_pipe.sv
bench/tb_dina_pipe_tb.sv

//--- Makefile
# Verilator build and run for the write-data path testbench.

VERILATOR ?= verilator
TOP       ?= tb_dina_pipe_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf $(OBJ_DIR)
